/* logic/control_pkg.sv */
package control_pkg;

  // command codes on the command port
  typedef enum logic [2:0] {
    cmd_speed_up   = 3'd1,
    cmd_speed_down = 3'd2,
    cmd_show_1     = 3'd3,
    cmd_show_2     = 3'd4,
    cmd_show_3     = 3'd5
  } cmd_code_t;  // 0, 6 and 7 are ignored

  // frame period is tick_divide * 2^(level+1) clocks
  typedef logic [2:0] speed_level_t;  // 0 fastest, 7 slowest

  typedef enum logic [1:0] {
    anim_1    = 2'd0,
    anim_2    = 2'd1,
    anim_3    = 2'd2,
    anim_none = 2'd3  // blank outputs
  } anim_sel_t;

  localparam speed_level_t reset_level   = 3'd5;
  localparam speed_level_t speed_fastest = 3'd0;
  localparam speed_level_t speed_slowest = 3'd7;

endpackage

/* logic/display_pkg.sv */
package display_pkg;

  // active low, bit 0 = segment a ... bit 6 = segment g
  typedef logic [6:0] segments_t;

  typedef logic [9:0] led_bar_t;

  typedef logic [6:0] frame_t;  // widest counter is 7 bits

  localparam int digit_count = 6;

  localparam segments_t seg_blank  = 7'b1111111;
  localparam segments_t seg_full   = 7'b0000000;
  localparam segments_t seg_a_only = 7'b1111110;

  // gfedcba, low means lit
  localparam segments_t hex_font [16] = '{
    7'b1000000,  // 0
    7'b1111001,  // 1
    7'b0100100,  // 2
    7'b0110000,  // 3
    7'b0011001,  // 4
    7'b0010010,  // 5
    7'b0000010,  // 6
    7'b1111000,  // 7
    7'b0000000,  // 8
    7'b0010000,  // 9
    7'b0001000,  // A
    7'b0000011,  // b
    7'b1000110,  // C
    7'b0100001,  // d
    7'b0000110,  // E
    7'b0001110   // F
  };

endpackage

/* logic/command_decoder.sv */
`timescale 1ns/1ps

module command_decoder (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      cmd_strobe,
  input  control_pkg::cmd_code_t    cmd_code,
  output control_pkg::speed_level_t speed_level,
  output control_pkg::anim_sel_t    chosen_anim
);

  import control_pkg::*;

  // speed register, saturating at both ends
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      speed_level <= reset_level;
    end else if (cmd_strobe) begin
      case (cmd_code)
        cmd_speed_up: begin
          if (speed_level != speed_fastest) begin
            speed_level <= speed_level - 3'd1;  // shorter period
          end
        end
        cmd_speed_down: begin
          if (speed_level != speed_slowest) begin
            speed_level <= speed_level + 3'd1;
          end
        end
        default: begin
        end
      endcase
    end
  end

  // last show command wins when several switches are on
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      chosen_anim <= anim_1;
    end else if (cmd_strobe) begin
      case (cmd_code)
        cmd_show_1: chosen_anim <= anim_1;
        cmd_show_2: chosen_anim <= anim_2;
        cmd_show_3: chosen_anim <= anim_3;
        default: begin
        end
      endcase
    end
  end

endmodule

/* logic/step_timer.sv */
`timescale 1ns/1ps

module step_timer #(
  parameter int tick_divide = 500000
) (
  input  logic                      clock,
  input  logic                      reset,
  input  control_pkg::speed_level_t speed_level,
  output logic                      frame_step
);

  localparam int prescale_width = $clog2(tick_divide + 1);

  logic [prescale_width-1:0] prescale_count;
  logic [7:0]                base_count;  // base ticks seen so far
  logic [7:0]                step_mask;
  logic                      base_tick;

  assign base_tick = (prescale_count == prescale_width'(tick_divide - 1));

  // low speed_level+1 bits set, level 7 gives all eight
  assign step_mask = ~(8'hfe << speed_level);

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      prescale_count <= '0;
    end else if (base_tick) begin
      prescale_count <= '0;
    end else begin
      prescale_count <= prescale_count + 1'b1;
    end
  end

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      base_count <= '0;
    end else if (base_tick) begin
      base_count <= base_count + 8'd1;
    end
  end

  // fires on the tick that completes 2^(level+1) base ticks
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      frame_step <= 1'b0;
    end else begin
      frame_step <= base_tick && ((base_count & step_mask) == step_mask);
    end
  end

endmodule

/* logic/frame_counters.sv */
`timescale 1ns/1ps

module frame_counters (
  input  logic                clock,
  input  logic                reset,
  input  logic                frame_step,
  input  logic [2:0]          switch_on,
  output display_pkg::frame_t frame_1,
  output display_pkg::frame_t frame_2,
  output display_pkg::frame_t frame_3
);

  import display_pkg::*;

  frame_t frames [3];

  for (genvar i = 0; i < 3; i++) begin : g_counter
    localparam int width = (i == 2) ? 7 : 5;  // animation 3 runs to 127

    logic [width-1:0] count;

    always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
        count <= '0;
      end else if (!switch_on[i]) begin
        count <= '0;  // held at zero while off
      end else if (frame_step) begin
        count <= count + 1'b1;  // wraps
      end
    end

    assign frames[i] = frame_t'(count);
  end

  assign frame_1 = frames[0];
  assign frame_2 = frames[1];
  assign frame_3 = frames[2];

endmodule

/* logic/frame_renderer.sv */
`timescale 1ns/1ps

module frame_renderer (
  input  display_pkg::frame_t      frame_1,
  input  display_pkg::frame_t      frame_2,
  input  display_pkg::frame_t      frame_3,
  output display_pkg::segments_t   anim_hex [3][display_pkg::digit_count],
  output display_pkg::led_bar_t    anim_led [3]
);

  import display_pkg::*;

  logic [2:0]  chase_pos;   // lit digit of the chase
  logic [3:0]  chase_led;
  logic [2:0]  fill_len;    // digits filled, 0..6
  logic [3:0]  fill_count;  // leds filled, 0..10
  logic [10:0] fill_bar;

  assign chase_pos  = 3'(frame_1 % 6);
  assign chase_led  = 4'(frame_1 % 10);
  assign fill_len   = 3'(frame_2 % 7);
  assign fill_count = 4'(frame_2 % 11);

  // one bit wider so a count of 10 lights the whole bar
  assign fill_bar = (11'd1 << fill_count) - 11'd1;

  always_comb begin
    for (int d = 0; d < digit_count; d++) begin
      anim_hex[0][d] = (d == chase_pos) ? seg_a_only : seg_blank;
      anim_hex[1][d] = (d < fill_len) ? seg_full : seg_blank;
      anim_hex[2][d] = seg_blank;
    end
    // counter display on the two right digits
    anim_hex[2][0] = hex_font[frame_3[3:0]];
    anim_hex[2][1] = hex_font[{1'b0, frame_3[6:4]}];
  end

  assign anim_led[0] = led_bar_t'(1) << chase_led;
  assign anim_led[1] = led_bar_t'(fill_bar);
  assign anim_led[2] = led_bar_t'(frame_3);  // binary frame number

endmodule

/* logic/display_select.sv */
`timescale 1ns/1ps

module display_select (
  input  logic [2:0]             switch_on,
  input  control_pkg::anim_sel_t chosen_anim,
  input  display_pkg::segments_t anim_hex [3][display_pkg::digit_count],
  input  display_pkg::led_bar_t  anim_led [3],
  output display_pkg::segments_t hex [display_pkg::digit_count],
  output display_pkg::led_bar_t  led
);

  import control_pkg::*;
  import display_pkg::*;

  anim_sel_t shown;

  // a single switch decides alone, several defer to the last show command
  always_comb begin
    case (switch_on)
      3'b000:  shown = anim_none;
      3'b001:  shown = anim_1;
      3'b010:  shown = anim_2;
      3'b100:  shown = anim_3;
      default: shown = chosen_anim;
    endcase
  end

  always_comb begin
    if (shown == anim_none) begin
      for (int d = 0; d < digit_count; d++) begin
        hex[d] = seg_blank;
      end
      led = '0;
    end else begin
      for (int d = 0; d < digit_count; d++) begin
        hex[d] = anim_hex[shown][d];
      end
      led = anim_led[shown];
    end
  end

endmodule

/* logic/animation_player.sv */
`timescale 1ns/1ps

module animation_player #(
  parameter int tick_divide = 500000  // clocks per base tick
) (
  input  logic                   clock,
  input  logic                   reset,
  input  logic [2:0]             switch_on,
  input  logic                   cmd_strobe,
  input  control_pkg::cmd_code_t cmd_code,
  output display_pkg::segments_t hex [display_pkg::digit_count],
  output display_pkg::led_bar_t  led
);

  import control_pkg::*;
  import display_pkg::*;

  speed_level_t speed_level;
  anim_sel_t    chosen_anim;
  logic         frame_step;
  frame_t       frame_1;
  frame_t       frame_2;
  frame_t       frame_3;
  segments_t    anim_hex [3][digit_count];
  led_bar_t     anim_led [3];

  command_decoder u_command_decoder (
    .clock       (clock),
    .reset       (reset),
    .cmd_strobe  (cmd_strobe),
    .cmd_code    (cmd_code),
    .speed_level (speed_level),
    .chosen_anim (chosen_anim)
  );

  step_timer #(
    .tick_divide (tick_divide)
  ) u_step_timer (
    .clock       (clock),
    .reset       (reset),
    .speed_level (speed_level),
    .frame_step  (frame_step)
  );

  frame_counters u_frame_counters (
    .clock      (clock),
    .reset      (reset),
    .frame_step (frame_step),
    .switch_on  (switch_on),
    .frame_1    (frame_1),
    .frame_2    (frame_2),
    .frame_3    (frame_3)
  );

  frame_renderer u_frame_renderer (
    .frame_1  (frame_1),
    .frame_2  (frame_2),
    .frame_3  (frame_3),
    .anim_hex (anim_hex),
    .anim_led (anim_led)
  );

  display_select u_display_select (
    .switch_on   (switch_on),
    .chosen_anim (chosen_anim),
    .anim_hex    (anim_hex),
    .anim_led    (anim_led),
    .hex         (hex),
    .led         (led)
  );

endmodule

/* bench/player_checks.svh */
`ifndef player_checks_svh
`define player_checks_svh

task automatic stop_with_failure(input string reason);
  $display("%s", reason);
  $display("CHECKS FAILED");
  $fatal(1, "simulation stopped on the first error");
endtask

task automatic check_value(input string name, input logic [51:0] expected,
                           input logic [51:0] actual);
  if (expected !== actual) begin
    stop_with_failure($sformatf("mismatch %s expected %0h actual %0h",
                                name, expected, actual));
  end
endtask

// active low gfedcba
function automatic logic [6:0] font_segments(input int value);
  case (value)
    0:       return 7'h40;
    1:       return 7'h79;
    2:       return 7'h24;
    3:       return 7'h30;
    4:       return 7'h19;
    5:       return 7'h12;
    6:       return 7'h02;
    7:       return 7'h78;
    8:       return 7'h00;
    9:       return 7'h10;
    10:      return 7'h08;
    11:      return 7'h03;
    12:      return 7'h46;
    13:      return 7'h21;
    14:      return 7'h06;
    default: return 7'h0e;
  endcase
endfunction

// digit d at bits 10+7d, leds at 9:0
function automatic logic [51:0] expected_pattern(input int anim, input int frame);
  logic [6:0]  digit [6];
  logic [9:0]  bar;
  logic [51:0] packed_out;
  int          k;
  bar = '0;
  for (k = 0; k < 6; k++) begin
    digit[k] = 7'h7f;  // dark
  end
  case (anim)
    0: begin
      digit[frame % 6] = 7'h7e;  // segment a only
      bar[frame % 10]  = 1'b1;
    end
    1: begin
      for (k = 0; k < frame % 7; k++) begin
        digit[k] = 7'h00;
      end
      for (k = 0; k < frame % 11; k++) begin
        bar[k] = 1'b1;
      end
    end
    2: begin
      digit[0] = font_segments(frame % 16);
      digit[1] = font_segments(frame / 16);
      bar      = 10'(frame);
    end
    default: begin
    end
  endcase
  packed_out[9:0] = bar;
  for (k = 0; k < 6; k++) begin
    packed_out[10 + 7 * k +: 7] = digit[k];
  end
  return packed_out;
endfunction

`endif

/* bench/player_tb.sv */
`timescale 1ns/1ps

module player_tb;

  import control_pkg::*;
  import display_pkg::*;

  localparam int tick_divide = 4;
  localparam int start_level = 5;
  localparam int max_rows    = 32;

  logic       clock;
  logic       reset;
  logic [2:0] switch_on;
  logic       cmd_strobe;
  cmd_code_t  cmd_code;
  segments_t  hex [digit_count];
  led_bar_t   led;

  int     model_level;   // expected speed level
  int     model_chosen;  // 0..2 from the last show command
  integer seed;

  string      row_name    [max_rows];
  logic [2:0] row_switch  [max_rows];
  bit         row_send    [max_rows];
  cmd_code_t  row_code    [max_rows];
  int         row_changes [max_rows];
  int         row_count;

  `include "player_checks.svh"

  animation_player #(
    .tick_divide (tick_divide)
  ) u_animation_player (
    .clock      (clock),
    .reset      (reset),
    .switch_on  (switch_on),
    .cmd_strobe (cmd_strobe),
    .cmd_code   (cmd_code),
    .hex        (hex),
    .led        (led)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  function automatic logic [51:0] observed_outputs();
    logic [51:0] packed_out;
    int          k;
    packed_out[9:0] = led;
    for (k = 0; k < 6; k++) begin
      packed_out[10 + 7 * k +: 7] = hex[k];
    end
    return packed_out;
  endfunction

  // 3 means blank
  function automatic int shown_anim(input logic [2:0] sw);
    case (sw)
      3'b000:  return 3;
      3'b001:  return 0;
      3'b010:  return 1;
      3'b100:  return 2;
      default: return model_chosen;
    endcase
  endfunction

  function automatic cmd_code_t show_code(input int anim);
    case (anim)
      0:       return cmd_show_1;
      1:       return cmd_show_2;
      default: return cmd_show_3;
    endcase
  endfunction

  task automatic apply_to_model(input cmd_code_t code);
    case (code)
      cmd_speed_up:   model_level = (model_level > 0) ? model_level - 1 : 0;
      cmd_speed_down: model_level = (model_level < 7) ? model_level + 1 : 7;
      cmd_show_1:     model_chosen = 0;
      cmd_show_2:     model_chosen = 1;
      cmd_show_3:     model_chosen = 2;
      default: begin
      end
    endcase
  endtask

  task automatic add_row(input string name, input logic [2:0] sw, input bit send,
                         input cmd_code_t code, input int changes);
    row_name[row_count]    = name;
    row_switch[row_count]  = sw;
    row_send[row_count]    = send;
    row_code[row_count]    = code;
    row_changes[row_count] = changes;
    row_count++;
  endtask

  task automatic wait_for_change(input string name, input logic [51:0] last,
                                 input int limit, output int gap);
    gap = 0;
    while (observed_outputs() === last && gap < limit) begin
      @(negedge clock);
      gap++;
    end
    if (observed_outputs() === last) begin
      stop_with_failure($sformatf("no output change within %0d cycles in %s", limit, name));
    end
  endtask

  // one clear cycle, then the new switches from frame 0
  task automatic run_row(input string name, input logic [2:0] sw, input bit send,
                         input cmd_code_t code, input int changes);
    int          anim;
    int          frame;
    int          wrap;
    int          period;
    int          gap;
    int          n;
    logic [51:0] last;
    @(posedge clock);
    #1;
    switch_on  = 3'b000;
    cmd_strobe = send;
    cmd_code   = code;
    if (send) begin
      apply_to_model(code);
    end
    @(posedge clock);
    #1;
    cmd_strobe = 1'b0;
    switch_on  = sw;
    @(negedge clock);
    anim   = shown_anim(sw);
    wrap   = (anim == 2) ? 128 : 32;
    period = tick_divide << (model_level + 1);
    frame  = 0;
    last   = observed_outputs();
    check_value(name, expected_pattern(anim, frame), last);
    for (n = 0; n < changes; n++) begin
      wait_for_change(name, last, 2 * period + 16, gap);
      frame = (frame + 1) % wrap;
      last  = observed_outputs();
      check_value(name, expected_pattern(anim, frame), last);
      if (n > 0) begin
        check_value({name, " period"}, period, gap);  // first gap may be short
      end
    end
  endtask

  task automatic random_run(input int rounds);
    logic [2:0] sw;
    bit         send;
    cmd_code_t  code;
    int         first;
    int         i;
    int         k;
    for (i = 0; i < rounds; i++) begin
      sw   = $random(seed);
      send = 1'b0;
      code = cmd_show_1;
      if (sw != 3'b000 && (sw & (sw - 3'd1)) != 3'b000) begin
        first = $unsigned($random(seed)) % 3;
        for (k = 0; k < 3; k++) begin
          if (sw[(first + k) % 3] && !send) begin
            send = 1'b1;
            code = show_code((first + k) % 3);  // keeps the shown counter running
          end
        end
      end else if ($random(seed) & 1) begin
        send = 1'b1;
        code = show_code($unsigned($random(seed)) % 3);
      end
      run_row($sformatf("random %0d", i), sw, send, code, (sw == 3'b000) ? 0 : 3);
    end
  endtask

  initial begin
    int r;
    model_level  = start_level;
    model_chosen = 0;
    seed         = 74;
    row_count    = 0;
    reset        = 1'b0;
    switch_on    = 3'b000;
    cmd_strobe   = 1'b0;
    cmd_code     = cmd_speed_up;
    repeat (8) @(posedge clock);
    #1;
    reset = 1'b1;

    add_row("blank after reset", 3'b000, 1'b0, cmd_speed_up, 0);
    add_row("anim 3 frame 0", 3'b100, 1'b0, cmd_speed_up, 0);
    add_row("period level 5", 3'b001, 1'b0, cmd_speed_up, 2);
    add_row("speed down to 6", 3'b001, 1'b1, cmd_speed_down, 2);
    add_row("speed down to 7", 3'b001, 1'b1, cmd_speed_down, 2);
    add_row("slowest saturates", 3'b001, 1'b1, cmd_speed_down, 2);
    add_row("speed up to 6", 3'b001, 1'b1, cmd_speed_up, 2);
    add_row("speed up to 5", 3'b001, 1'b1, cmd_speed_up, 2);
    add_row("speed up to 4", 3'b001, 1'b1, cmd_speed_up, 2);
    add_row("speed up to 3", 3'b001, 1'b1, cmd_speed_up, 2);
    add_row("speed up to 2", 3'b001, 1'b1, cmd_speed_up, 2);
    add_row("speed up to 1", 3'b001, 1'b1, cmd_speed_up, 2);
    add_row("speed up to 0", 3'b001, 1'b1, cmd_speed_up, 2);
    add_row("fastest saturates", 3'b001, 1'b1, cmd_speed_up, 2);
    add_row("chase sequence", 3'b001, 1'b0, cmd_speed_up, 34);  // wraps at 32
    add_row("fill sequence", 3'b010, 1'b0, cmd_speed_up, 12);
    add_row("counter sequence", 3'b100, 1'b0, cmd_speed_up, 130);
    add_row("two switches default", 3'b011, 1'b0, cmd_speed_up, 4);
    add_row("show 3 command", 3'b101, 1'b1, cmd_show_3, 4);
    add_row("unknown code", 3'b101, 1'b1, cmd_code_t'(3'd7), 4);
    add_row("show 2 command", 3'b111, 1'b1, cmd_show_2, 4);
    add_row("clear restart", 3'b111, 1'b0, cmd_speed_up, 4);
    add_row("all off blank", 3'b000, 1'b0, cmd_speed_up, 0);

    for (r = 0; r < row_count; r++) begin
      run_row(row_name[r], row_switch[r], row_send[r], row_code[r], row_changes[r]);
    end
    random_run(20);

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

/* sources.f */
+incdir+bench
logic/control_pkg.sv
logic/display_pkg.sv
logic/command_decoder.sv
logic/step_timer.sv
logic/frame_counters.sv
logic/frame_renderer.sv
logic/display_select.sv
logic/animation_player.sv
bench/player_tb.sv
